// File: sim.f
design/bus_pkg.sv
design/map_pkg.sv
design/tl_err_check.sv
design/tl_sink.sv
design/tl_reg_dev.sv
design/tl_addr_demux.sv
design/tl_subsys.sv
dv/tb_tl_subsys.sv

// File: Makefile
# Verilator build and run of the tl_subsys testbench

SRCS := $(shell cat sim.f)

.PHONY: run clean

run: obj_dir/Vtb_tl_subsys
	./obj_dir/Vtb_tl_subsys > sim.log 2>&1; cat sim.log
	grep -q "TESTBENCH PASSED" sim.log

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_tl_subsys: sim.f $(SRCS)
	verilator --binary --timing -f sim.f --top-module tb_tl_subsys -o Vtb_tl_subsys

clean:
	rm -rf obj_dir sim.log

// File: dv/tb_tl_subsys.sv
////////////////////////////////////////
// Self-checking testbench for the bus endpoint subsystem
// One request in flight
// The driver waits for a_ready
// Outputs are sampled on the falling clock edge
////////////////////////////////////////
`timescale 1ns/10ps

module tb_tl_subsys;

  localparam int src_w    = 4;
  localparam int num_regs = 4;
  localparam int idx_w    = $clog2(num_regs);
  localparam int max_wait = 200;
  localparam int num_rand = 400;
  localparam logic [31:0] seed = 32'he4a1_fd24;
  localparam logic [31:0] base = map_pkg::reg_base;

  // One D beat as expected or observed
  typedef struct packed {
    logic [2:0]                 op;
    logic [bus_pkg::size_w-1:0] size;
    logic [src_w-1:0]           src;
    logic [bus_pkg::data_w-1:0] data;
    logic                       err;
  } rsp_t;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       a_valid_i;
  logic                       a_ready_o;
  logic [2:0]                 a_opcode_i;
  logic [bus_pkg::size_w-1:0] a_size_i;
  logic [bus_pkg::addr_w-1:0] a_address_i;
  logic [bus_pkg::mask_w-1:0] a_mask_i;
  logic [bus_pkg::data_w-1:0] a_data_i;
  logic [src_w-1:0]           a_source_i;
  logic                       d_valid_o;
  logic                       d_ready_i;
  bus_pkg::d_op_e             d_opcode_o;
  logic [bus_pkg::size_w-1:0] d_size_o;
  logic [src_w-1:0]           d_source_o;
  logic [bus_pkg::data_w-1:0] d_data_o;
  logic                       d_error_o;

  // Reference state and scoreboard
  logic [31:0] model_regs [num_regs];
  rsp_t        exp_q [$];
  logic [31:0] stim_state;
  logic [31:0] rdy_state;
  bit          bp_on;
  int          n_err;
  int          n_acc;
  int          n_rsp;

  // Monitor history from the previous falling edge
  logic a_acc_prev;
  logic d_valid_prev;
  logic stall_prev;
  rsp_t held;
  rsp_t cur;
  rsp_t exp_rsp;

  tl_subsys #(
    .src_w    (src_w),
    .num_regs (num_regs)
  ) u_tl_subsys (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .a_valid_i   (a_valid_i),
    .a_ready_o   (a_ready_o),
    .a_opcode_i  (bus_pkg::a_op_e'(a_opcode_i)),
    .a_size_i    (a_size_i),
    .a_address_i (a_address_i),
    .a_mask_i    (a_mask_i),
    .a_data_i    (a_data_i),
    .a_source_i  (a_source_i),
    .d_valid_o   (d_valid_o),
    .d_ready_i   (d_ready_i),
    .d_opcode_o  (d_opcode_o),
    .d_size_o    (d_size_o),
    .d_source_o  (d_source_o),
    .d_data_o    (d_data_o),
    .d_error_o   (d_error_o)
  );

  always #5 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Random numbers
  ////////////////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    stim_state = xorshift32(stim_state);
    return stim_state;
  endfunction

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  // Byte lanes covered by size and low address bits
  function automatic logic [3:0] lanes_of(input logic [1:0] size, input logic [31:0] addr);
    case (size)
      2'd0: return 4'b0001 << addr[1:0];
      2'd1: return addr[1] ? 4'b1100 : 4'b0011;
      2'd2: return 4'b1111;
      default: return 4'b0000;
    endcase
  endfunction

  function automatic logic proto_err(input logic [2:0] op, input logic [1:0] size,
                                     input logic [31:0] addr, input logic [3:0] mask);
    logic [3:0] lanes;
    logic       bad;
    lanes = lanes_of(size, addr);
    bad   = !(op == 3'd0 || op == 3'd1 || op == 3'd4);
    bad   = bad || (size > 2'd2);
    bad   = bad || (size == 2'd1 && addr[0]) || (size == 2'd2 && addr[1:0] != 2'b00);
    // Put masks inside the lanes and full puts exactly on them
    bad   = bad || ((op == 3'd0 || op == 3'd1) && (mask & ~lanes) != 4'b0000);
    bad   = bad || (op == 3'd0 && mask != lanes);
    return bad;
  endfunction

  // Expected response and model update for a legal write
  function automatic rsp_t predict(input logic [2:0] op, input logic [1:0] size,
                                   input logic [31:0] addr, input logic [3:0] mask,
                                   input logic [31:0] data, input logic [src_w-1:0] src);
    rsp_t             e;
    logic [31:0]      off;
    logic [idx_w-1:0] idx;
    logic             is_put;
    logic             is_get;
    logic             err;
    off    = addr - base;
    idx    = off[idx_w+1:2];
    is_put = (op == 3'd0) || (op == 3'd1);
    is_get = (op == 3'd4);
    err    = proto_err(op, size, addr, mask);
    e.op   = is_get ? bus_pkg::access_ack_data : bus_pkg::access_ack;
    e.size = size;
    e.src  = src;
    e.data = '0;
    e.err  = err;
    if (addr >= base && off < 4 * num_regs) begin
      if (!err && is_put) begin
        for (int b = 0; b < 4; b++) begin
          if (mask[b]) model_regs[idx][8*b +: 8] = data[8*b +: 8];
        end
      end
      if (!err && is_get) e.data = model_regs[idx];
    end else begin
      // Unmapped writes only pass when word aligned with all bytes
      if (is_put && (addr[1:0] != 2'b00 || mask != 4'hf)) e.err = 1'b1;
    end
    return e;
  endfunction

  ////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////
  task automatic note_mismatch(input string msg);
    n_err++;
    $display("Mismatch at %0t: %s", $time, msg);
  endtask

  task automatic report_and_finish();
    $display("Errors: %0d  requests: %0d  responses: %0d", n_err, n_acc, n_rsp);
    if (n_err == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  task automatic stop_on_timeout(input string msg);
    n_err++;
    $display("Timeout at %0t: %s", $time, msg);
    report_and_finish();
  endtask

  ////////////////////////////////////////
  // Driver
  ////////////////////////////////////////
  // Entered and left 1 ns after a rising edge
  task automatic send_req(input logic [2:0] op, input logic [1:0] size,
                          input logic [31:0] addr, input logic [3:0] mask,
                          input logic [31:0] data);
    logic [31:0] r;
    int          t;
    r           = next_rand();
    a_valid_i   = 1'b1;
    a_opcode_i  = op;
    a_size_i    = size;
    a_address_i = addr;
    a_mask_i    = mask;
    a_data_i    = data;
    a_source_i  = r[src_w-1:0];
    t = 0;
    do begin
      @(negedge clk_i);
      t++;
    end while (!a_ready_o && t < max_wait);
    if (!a_ready_o) begin
      stop_on_timeout("the A request was never accepted");
    end else begin
      @(posedge clk_i);
      #1;
      a_valid_i = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while ((exp_q.size() != 0 || d_valid_o) && t < max_wait) begin
      @(negedge clk_i);
      #1;
      t++;
    end
    if (exp_q.size() != 0 || d_valid_o) begin
      n_err++;
      $display("Timeout at %0t: responses still pending at the end", $time);
    end
  endtask

  // Random back-pressure on D
  always @(posedge clk_i) begin
    #1;
    if (bp_on) begin
      rdy_state = xorshift32(rdy_state);
      d_ready_i = rdy_state[0];
    end else begin
      d_ready_i = 1'b1;
    end
  end

  ////////////////////////////////////////
  // Monitor and compare
  ////////////////////////////////////////
  always @(negedge clk_i) begin
    cur.op   = d_opcode_o;
    cur.size = d_size_o;
    cur.src  = d_source_o;
    cur.data = d_data_o;
    cur.err  = d_error_o;
    if (!rst_ni) begin
      a_acc_prev   = 1'b0;
      d_valid_prev = 1'b0;
      stall_prev   = 1'b0;
    end else begin
      // Response exactly one cycle after accept
      if (a_acc_prev && !d_valid_o) note_mismatch("d_valid low one cycle after the A handshake");
      if (d_valid_o && !d_valid_prev && !a_acc_prev) note_mismatch("d_valid rose with no accept");
      if (d_valid_o && a_ready_o) note_mismatch("a_ready high while a response is pending");
      // Stalled response must hold
      if (stall_prev && (!d_valid_o || cur != held)) begin
        note_mismatch("response changed while d_ready was low");
      end
      if (d_valid_o && d_ready_i) begin
        n_rsp++;
        if (exp_q.size() == 0) begin
          n_err++;
          $display("A response arrived at %0t with no request outstanding", $time);
        end else begin
          exp_rsp = exp_q.pop_front();
          if (cur.op != exp_rsp.op) begin
            note_mismatch($sformatf("d_opcode %0d, expected %0d", cur.op, exp_rsp.op));
          end
          if (cur.size != exp_rsp.size) begin
            note_mismatch($sformatf("d_size %0d, expected %0d", cur.size, exp_rsp.size));
          end
          if (cur.src != exp_rsp.src) begin
            note_mismatch($sformatf("d_source %0d, expected %0d", cur.src, exp_rsp.src));
          end
          if (cur.data != exp_rsp.data) begin
            note_mismatch($sformatf("d_data %h, expected %h", cur.data, exp_rsp.data));
          end
          if (cur.err != exp_rsp.err) begin
            note_mismatch($sformatf("d_error %b, expected %b", cur.err, exp_rsp.err));
          end
        end
      end
      if (a_valid_i && a_ready_o) begin
        n_acc++;
        exp_q.push_back(predict(a_opcode_i, a_size_i, a_address_i, a_mask_i, a_data_i,
                                a_source_i));
      end
      a_acc_prev   = a_valid_i && a_ready_o;
      d_valid_prev = d_valid_o;
      stall_prev   = d_valid_o && !d_ready_i;
      held         = cur;
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  initial begin
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  mask;
    logic [2:0]  op;
    logic [1:0]  sz;
    stim_state  = seed;
    rdy_state   = ~seed;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    a_valid_i   = 1'b0;
    a_opcode_i  = '0;
    a_size_i    = '0;
    a_address_i = '0;
    a_mask_i    = '0;
    a_data_i    = '0;
    a_source_i  = '0;
    d_ready_i   = 1'b1;
    bp_on       = 1'b0;
    n_err       = 0;
    n_acc       = 0;
    n_rsp       = 0;
    for (int i = 0; i < num_regs; i++) model_regs[i] = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    if (!a_ready_o || d_valid_o) note_mismatch("a_ready low or d_valid high after reset");
    @(posedge clk_i);
    #1;

    // Unwritten register then full write and read back
    send_req(3'd4, 2'd2, base, 4'hf, '0);
    send_req(3'd0, 2'd2, base + 4, 4'hf, 32'hcafe_0123);
    send_req(3'd4, 2'd2, base + 4, 4'hf, '0);

    // Partial writes with legal masks
    for (int i = 0; i < 24; i++) begin
      r    = next_rand();
      sz   = (r[1:0] == 2'd3) ? 2'd2 : r[1:0];
      addr = base + 4 * (r[7:6] % num_regs);
      if (sz == 2'd0) addr[1:0] = r[5:4];
      if (sz == 2'd1) addr[1] = r[5];
      mask = lanes_of(sz, addr) & r[11:8];
      send_req(3'd1, sz, addr, mask, next_rand());
      send_req(3'd4, 2'd2, {addr[31:2], 2'b00}, 4'hf, '0);
    end

    // Register errors leave the word unchanged
    send_req(3'd0, 2'd2, base + 8, 4'hf, 32'h1234_5678);
    send_req(3'd0, 2'd3, base + 8, 4'hf, 32'hdead_beef);
    send_req(3'd0, 2'd2, base + 9, 4'hf, 32'hdead_beef);
    send_req(3'd1, 2'd0, base + 8, 4'b0010, 32'hdead_beef);
    send_req(3'd2, 2'd2, base + 8, 4'hf, 32'hdead_beef);
    send_req(3'd0, 2'd1, base + 8, 4'b0001, 32'hdead_beef);
    send_req(3'd4, 2'd2, base + 8, 4'hf, '0);

    // Sink clean acks then its error cases
    send_req(3'd4, 2'd2, 32'h0000_1000, 4'hf, '0);
    send_req(3'd0, 2'd2, 32'h0000_1000, 4'hf, 32'h5555_aaaa);
    send_req(3'd4, 2'd2, base + 4 * num_regs, 4'hf, '0);
    send_req(3'd1, 2'd2, 32'h0000_1004, 4'b0011, 32'h0bad_0bad);
    send_req(3'd1, 2'd0, 32'h0000_1001, 4'b0010, 32'h0bad_0bad);
    send_req(3'd4, 2'd3, 32'h0000_1000, 4'hf, '0);

    // Random mix under back-pressure
    bp_on = 1'b1;
    for (int i = 0; i < num_rand; i++) begin
      r = next_rand();
      case (r[2:0])
        3'd0, 3'd1, 3'd2: op = 3'd0;
        3'd3, 3'd4:       op = 3'd1;
        3'd5, 3'd6:       op = 3'd4;
        default:          op = {r[9], 1'b1, r[8]};
      endcase
      sz = r[13] ? 2'd2 : r[12:11];
      if (r[14]) begin
        addr = base + (next_rand() % (4 * num_regs));
      end else if (r[15]) begin
        addr = base + 4 * num_regs + (next_rand() % 8);
      end else begin
        addr = next_rand();
      end
      // Mostly aligned
      if (r[16] && sz == 2'd1) addr[0] = 1'b0;
      if (r[16] && sz >= 2'd2) addr[1:0] = 2'b00;
      mask = r[17] ? (lanes_of(sz, addr) & (r[18] ? r[23:20] : 4'hf)) : r[23:20];
      data = next_rand();
      send_req(op, sz, addr, mask, data);
    end

    wait_drain();
    if (n_rsp != n_acc) begin
      n_err++;
      $display("Response count %0d does not match request count %0d", n_rsp, n_acc);
    end
    report_and_finish();
  end

endmodule

// File: design/tl_subsys.sv
////////////////////////////////////////
// Bus endpoint subsystem, register bank plus sink
// One request in flight, response one cycle after accept
////////////////////////////////////////
`timescale 1ns/10ps

module tl_subsys #(
  parameter int src_w    = 4,
  parameter int num_regs = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        a_valid_i,
  output logic                        a_ready_o,
  input  bus_pkg::a_op_e              a_opcode_i,
  input  logic [bus_pkg::size_w-1:0]  a_size_i,
  input  logic [bus_pkg::addr_w-1:0]  a_address_i,
  input  logic [bus_pkg::mask_w-1:0]  a_mask_i,
  input  logic [bus_pkg::data_w-1:0]  a_data_i,
  input  logic [src_w-1:0]            a_source_i,
  output logic                        d_valid_o,
  input  logic                        d_ready_i,
  output bus_pkg::d_op_e              d_opcode_o,
  output logic [bus_pkg::size_w-1:0]  d_size_o,
  output logic [src_w-1:0]            d_source_o,
  output logic [bus_pkg::data_w-1:0]  d_data_o,
  output logic                        d_error_o
);

  // Register device channel
  logic                       reg_a_valid;
  logic                       reg_a_ready;
  logic                       reg_d_valid;
  logic                       reg_d_ready;
  bus_pkg::d_op_e             reg_d_opcode;
  logic [bus_pkg::size_w-1:0] reg_d_size;
  logic [src_w-1:0]           reg_d_source;
  logic [bus_pkg::data_w-1:0] reg_d_data;
  logic                       reg_d_error;

  // Sink channel
  logic                       snk_a_valid;
  logic                       snk_a_ready;
  logic                       snk_d_valid;
  logic                       snk_d_ready;
  bus_pkg::d_op_e             snk_d_opcode;
  logic [bus_pkg::size_w-1:0] snk_d_size;
  logic [src_w-1:0]           snk_d_source;
  logic                       snk_d_error;

  // Decode and response return
  tl_addr_demux #(
    .src_w    (src_w),
    .num_regs (num_regs)
  ) u_tl_addr_demux (
    .clk_i, .rst_ni,
    .a_valid_i, .a_ready_o, .a_address_i,
    .d_valid_o, .d_ready_i, .d_opcode_o, .d_size_o, .d_source_o, .d_data_o, .d_error_o,
    .reg_a_valid_o  (reg_a_valid),
    .reg_a_ready_i  (reg_a_ready),
    .reg_d_valid_i  (reg_d_valid),
    .reg_d_ready_o  (reg_d_ready),
    .reg_d_opcode_i (reg_d_opcode),
    .reg_d_size_i   (reg_d_size),
    .reg_d_source_i (reg_d_source),
    .reg_d_data_i   (reg_d_data),
    .reg_d_error_i  (reg_d_error),
    .snk_a_valid_o  (snk_a_valid),
    .snk_a_ready_i  (snk_a_ready),
    .snk_d_valid_i  (snk_d_valid),
    .snk_d_ready_o  (snk_d_ready),
    .snk_d_opcode_i (snk_d_opcode),
    .snk_d_size_i   (snk_d_size),
    .snk_d_source_i (snk_d_source),
    .snk_d_error_i  (snk_d_error)
  );

  // A payload fans out, only valid is steered
  tl_reg_dev #(
    .src_w    (src_w),
    .num_regs (num_regs)
  ) u_tl_reg_dev (
    .clk_i, .rst_ni,
    .a_valid_i (reg_a_valid),
    .a_ready_o (reg_a_ready),
    .a_opcode_i, .a_size_i, .a_address_i, .a_mask_i, .a_data_i, .a_source_i,
    .d_valid_o  (reg_d_valid),
    .d_ready_i  (reg_d_ready),
    .d_opcode_o (reg_d_opcode),
    .d_size_o   (reg_d_size),
    .d_source_o (reg_d_source),
    .d_data_o   (reg_d_data),
    .d_error_o  (reg_d_error)
  );

  tl_sink #(
    .src_w (src_w)
  ) u_tl_sink (
    .clk_i, .rst_ni,
    .a_valid_i (snk_a_valid),
    .a_ready_o (snk_a_ready),
    .a_opcode_i, .a_size_i, .a_address_i, .a_mask_i, .a_source_i,
    .d_valid_o  (snk_d_valid),
    .d_ready_i  (snk_d_ready),
    .d_opcode_o (snk_d_opcode),
    .d_size_o   (snk_d_size),
    .d_source_o (snk_d_source),
    .d_error_o  (snk_d_error)
  );

endmodule

// File: design/tl_addr_demux.sv
////////////////////////////////////////
// Address decoder for a single outstanding request
// Both paths are combinational, only busy and select are held
// Next accept is the cycle after the host D handshake
////////////////////////////////////////
`timescale 1ns/10ps

module tl_addr_demux #(
  parameter int src_w    = 4,
  parameter int num_regs = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Host side
  input  logic                        a_valid_i,
  output logic                        a_ready_o,
  input  logic [bus_pkg::addr_w-1:0]  a_address_i,
  output logic                        d_valid_o,
  input  logic                        d_ready_i,
  output bus_pkg::d_op_e              d_opcode_o,
  output logic [bus_pkg::size_w-1:0]  d_size_o,
  output logic [src_w-1:0]            d_source_o,
  output logic [bus_pkg::data_w-1:0]  d_data_o,
  output logic                        d_error_o,
  // Register device
  output logic                        reg_a_valid_o,
  input  logic                        reg_a_ready_i,
  input  logic                        reg_d_valid_i,
  output logic                        reg_d_ready_o,
  input  bus_pkg::d_op_e              reg_d_opcode_i,
  input  logic [bus_pkg::size_w-1:0]  reg_d_size_i,
  input  logic [src_w-1:0]            reg_d_source_i,
  input  logic [bus_pkg::data_w-1:0]  reg_d_data_i,
  input  logic                        reg_d_error_i,
  // Sink
  output logic                        snk_a_valid_o,
  input  logic                        snk_a_ready_i,
  input  logic                        snk_d_valid_i,
  output logic                        snk_d_ready_o,
  input  bus_pkg::d_op_e              snk_d_opcode_i,
  input  logic [bus_pkg::size_w-1:0]  snk_d_size_i,
  input  logic [src_w-1:0]            snk_d_source_i,
  input  logic                        snk_d_error_i
);

  // Window length in bytes
  localparam logic [bus_pkg::addr_w-1:0] win_bytes = 4 * num_regs;

  logic                       hit_reg;
  logic                       busy_q;
  logic                       sel_reg_q;
  logic [bus_pkg::addr_w-1:0] offset;

  ////////////////////////////////////////
  // A path
  ////////////////////////////////////////
  // Below reg_base the subtraction wraps, so test both bounds
  assign offset  = a_address_i - map_pkg::reg_base;
  assign hit_reg = (a_address_i >= map_pkg::reg_base) && (offset < win_bytes);

  assign a_ready_o     = ~busy_q & (hit_reg ? reg_a_ready_i : snk_a_ready_i);
  assign reg_a_valid_o = a_valid_i & ~busy_q & hit_reg;
  assign snk_a_valid_o = a_valid_i & ~busy_q & ~hit_reg;

  // Busy from accept to host D handshake, select held alongside
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      sel_reg_q <= 1'b0;
    end else if (a_valid_i && a_ready_o) begin
      busy_q    <= 1'b1;
      sel_reg_q <= hit_reg;
    end else if (d_valid_o && d_ready_i) begin
      busy_q    <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // D path
  ////////////////////////////////////////
  // Sink has no data, returns zero
  assign d_valid_o     = sel_reg_q ? reg_d_valid_i : snk_d_valid_i;
  assign d_opcode_o    = sel_reg_q ? reg_d_opcode_i : snk_d_opcode_i;
  assign d_size_o      = sel_reg_q ? reg_d_size_i : snk_d_size_i;
  assign d_source_o    = sel_reg_q ? reg_d_source_i : snk_d_source_i;
  assign d_data_o      = sel_reg_q ? reg_d_data_i : '0;
  assign d_error_o     = sel_reg_q ? reg_d_error_i : snk_d_error_i;
  assign reg_d_ready_o = d_ready_i & sel_reg_q;
  assign snk_d_ready_o = d_ready_i & ~sel_reg_q;

endmodule

// File: design/tl_reg_dev.sv
////////////////////////////////////////
// Bank of word registers behind the A channel
// Only sees requests inside its window, the demux decodes it
// Errored requests never write and return zero data
////////////////////////////////////////
`timescale 1ns/10ps

module tl_reg_dev #(
  parameter int src_w    = 4,
  parameter int num_regs = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        a_valid_i,
  output logic                        a_ready_o,
  input  bus_pkg::a_op_e              a_opcode_i,
  input  logic [bus_pkg::size_w-1:0]  a_size_i,
  input  logic [bus_pkg::addr_w-1:0]  a_address_i,
  input  logic [bus_pkg::mask_w-1:0]  a_mask_i,
  input  logic [bus_pkg::data_w-1:0]  a_data_i,
  input  logic [src_w-1:0]            a_source_i,
  output logic                        d_valid_o,
  input  logic                        d_ready_i,
  output bus_pkg::d_op_e              d_opcode_o,
  output logic [bus_pkg::size_w-1:0]  d_size_o,
  output logic [src_w-1:0]            d_source_o,
  output logic [bus_pkg::data_w-1:0]  d_data_o,
  output logic                        d_error_o
);

  // Index width, at least one bit
  localparam int idx_w = (num_regs > 1) ? $clog2(num_regs) : 1;

  logic                       a_ack;
  logic                       d_ack;
  logic                       pending_q;
  logic                       chk_err;
  logic                       rd_req;
  logic                       wr_en;
  logic [bus_pkg::addr_w-1:0] offset;
  logic [idx_w-1:0]           idx;
  logic [bus_pkg::data_w-1:0] regs_q [num_regs];

  assign a_ack  = a_valid_i & a_ready_o;
  assign d_ack  = d_valid_o & d_ready_i;
  assign rd_req = (a_opcode_i == bus_pkg::get);

  // Word index from the window offset
  assign offset = a_address_i - map_pkg::reg_base;
  assign idx    = offset[idx_w+1:2];

  // Only clean puts reach the storage
  assign wr_en = a_ack & ~rd_req & ~chk_err;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (a_ack) begin
      pending_q <= 1'b1;
    end else if (d_ack) begin
      pending_q <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Register storage
  ////////////////////////////////////////
  // Merge enabled bytes only
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regs_q <= '{default: '0};
    end else if (wr_en) begin
      for (int b = 0; b < bus_pkg::mask_w; b++) begin
        if (a_mask_i[b]) regs_q[idx][8*b +: 8] <= a_data_i[8*b +: 8];
      end
    end
  end

  // Response capture, read data zeroed on error
  always_ff @(posedge clk_i) begin
    if (a_ack) begin
      d_opcode_o <= rd_req ? bus_pkg::access_ack_data : bus_pkg::access_ack;
      d_size_o   <= a_size_i;
      d_source_o <= a_source_i;
      d_data_o   <= (rd_req && !chk_err) ? regs_q[idx] : '0;
      d_error_o  <= chk_err;
    end
  end

  tl_err_check #(
    .src_w (src_w)
  ) u_err_check (
    .a_opcode_i  (a_opcode_i),
    .a_size_i    (a_size_i),
    .a_address_i (a_address_i),
    .a_mask_i    (a_mask_i),
    .err_o       (chk_err)
  );

  assign a_ready_o = ~pending_q;
  assign d_valid_o = pending_q;

endmodule

// File: design/tl_sink.sv
////////////////////////////////////////
// Terminating endpoint for unmapped addresses
// Acks every request, data is always zero
// Writes must be word aligned with a full mask
////////////////////////////////////////
`timescale 1ns/10ps

module tl_sink #(
  parameter int src_w = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        a_valid_i,
  output logic                        a_ready_o,
  input  bus_pkg::a_op_e              a_opcode_i,
  input  logic [bus_pkg::size_w-1:0]  a_size_i,
  input  logic [bus_pkg::addr_w-1:0]  a_address_i,
  input  logic [bus_pkg::mask_w-1:0]  a_mask_i,
  input  logic [src_w-1:0]            a_source_i,
  output logic                        d_valid_o,
  input  logic                        d_ready_i,
  output bus_pkg::d_op_e              d_opcode_o,
  output logic [bus_pkg::size_w-1:0]  d_size_o,
  output logic [src_w-1:0]            d_source_o,
  output logic                        d_error_o
);

  logic a_ack;
  logic d_ack;
  logic pending_q;
  logic wr_req;
  logic rd_req;
  logic chk_err;
  logic wr_rule_err;

  assign a_ack  = a_valid_i & a_ready_o;
  assign d_ack  = d_valid_o & d_ready_i;
  assign wr_req = (a_opcode_i == bus_pkg::put_full_data) |
                  (a_opcode_i == bus_pkg::put_partial_data);
  assign rd_req = (a_opcode_i == bus_pkg::get);

  // Pending response, blocks A until the D handshake
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (a_ack) begin
      pending_q <= 1'b1;
    end else if (d_ack) begin
      pending_q <= 1'b0;
    end
  end

  // Response fields captured on accept
  always_ff @(posedge clk_i) begin
    if (a_ack) begin
      d_opcode_o <= rd_req ? bus_pkg::access_ack_data : bus_pkg::access_ack;
      d_size_o   <= a_size_i;
      d_source_o <= a_source_i;
      d_error_o  <= chk_err | wr_rule_err;
    end
  end

  ////////////////////////////////////////
  // Errors
  ////////////////////////////////////////
  // Sink only takes aligned full word writes
  assign wr_rule_err = wr_req & ((|a_address_i[1:0]) | ~(&a_mask_i));

  tl_err_check #(
    .src_w (src_w)
  ) u_err_check (
    .a_opcode_i  (a_opcode_i),
    .a_size_i    (a_size_i),
    .a_address_i (a_address_i),
    .a_mask_i    (a_mask_i),
    .err_o       (chk_err)
  );

  assign a_ready_o = ~pending_q;
  assign d_valid_o = pending_q;

endmodule

// File: design/tl_err_check.sv
////////////////////////////////////////
// Protocol checker for one A channel request
// Purely combinational
// Result is valid while a_valid is high
// Get masks are not checked
////////////////////////////////////////
`timescale 1ns/10ps

module tl_err_check #(
  parameter int src_w = 4
) (
  input  bus_pkg::a_op_e              a_opcode_i,
  input  logic [bus_pkg::size_w-1:0]  a_size_i,
  input  logic [bus_pkg::addr_w-1:0]  a_address_i,
  input  logic [bus_pkg::mask_w-1:0]  a_mask_i,
  output logic                        err_o
);

  logic                       op_legal;
  logic                       is_put;
  logic                       is_full;
  logic                       size_err;
  logic                       align_err;
  logic                       mask_err;
  logic [bus_pkg::mask_w-1:0] lanes;

  // Opcode decode
  always_comb begin
    op_legal = 1'b1;
    is_put   = 1'b0;
    is_full  = 1'b0;
    case (a_opcode_i)
      bus_pkg::put_full_data: begin
        is_put  = 1'b1;
        is_full = 1'b1;
      end
      bus_pkg::put_partial_data: is_put = 1'b1;
      bus_pkg::get: op_legal = 1'b1;
      default: op_legal = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Byte lanes and alignment
  ////////////////////////////////////////
  always_comb begin
    lanes     = '0;
    align_err = 1'b0;
    case (a_size_i)
      // Byte at any address
      2'd0: lanes = {{(bus_pkg::mask_w-1){1'b0}}, 1'b1} << a_address_i[1:0];
      // Half word on an even address
      2'd1: begin
        lanes     = {{(bus_pkg::mask_w-2){1'b0}}, 2'b11} << {a_address_i[1], 1'b0};
        align_err = a_address_i[0];
      end
      // Full word on a word address
      2'd2: begin
        lanes     = '1;
        align_err = |a_address_i[1:0];
      end
      // Wider than the bus is flagged by size_err
      default: lanes = '0;
    endcase
  end

  assign size_err = (a_size_i > 2'd2);

  // Partial mask inside the lanes and full mask equal to them
  assign mask_err = (is_put & ((a_mask_i & ~lanes) != '0)) |
                    (is_full & (a_mask_i != lanes));

  assign err_o = ~op_legal | size_err | align_err | mask_err;

endmodule

// File: design/map_pkg.sv
////////////////////////////////////////
// Address map of the subsystem
// The register window starts at reg_base and spans one word
// per register, its length is set by the num_regs parameter
////////////////////////////////////////
package map_pkg;

  ////////////////////////////////////////
  // Register window
  ////////////////////////////////////////
  // Base of the register bank
  // Must be word aligned
  // Everything outside the window falls through to the sink
  localparam logic [bus_pkg::addr_w-1:0] reg_base = 32'h4000_0000;

endpackage

// File: design/bus_pkg.sv
////////////////////////////////////////
// Protocol types and widths for a TL-UL style bus
// Single beat only, so size never exceeds one data word
// Opcode codes outside the enums are legal on the wire and
// are caught by the protocol checker, not by the type
////////////////////////////////////////
package bus_pkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////
  // Byte address
  localparam int addr_w = 32;
  // One data beat, one word
  localparam int data_w = 32;
  // One mask bit per byte lane
  localparam int mask_w = data_w / 8;
  // Log2 of the transfer size in bytes
  localparam int size_w = 2;

  ////////////////////////////////////////
  // Channel opcodes
  ////////////////////////////////////////
  // A channel requests, other codes are illegal
  typedef enum logic [2:0] {
    put_full_data    = 3'd0,
    put_partial_data = 3'd1,
    get              = 3'd4
  } a_op_e;

  // D channel responses
  // Data variant only for get
  typedef enum logic [2:0] {
    access_ack      = 3'd0,
    access_ack_data = 3'd1
  } d_op_e;

endpackage
